// ==== i2c_macros.svh ====
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// clk cycles per quarter of an scl period.
`define I2C_PHASE_CYCLES 4

// 7-bit addressing only.
`define I2C_ADDR_W 7

// one data byte per transfer.
`define I2C_DATA_W 8

// digit toggles every 2**SEG_REFRESH_BITS cycles.
`define SEG_REFRESH_BITS 3

`endif

// ==== i2c_pkg.sv ====
package i2c_pkg;

  // quarters of one bit time, scl low in ph_low1 and ph_fall.
  typedef enum logic [1:0] {
    ph_low1 = 2'd0,
    ph_rise = 2'd1,
    ph_high = 2'd2,
    ph_fall = 2'd3
  } i2c_phase_t;

  // transfer sequence of the master.
  typedef enum logic [2:0] {
    st_idle  = 3'd0,
    st_start = 3'd1,
    st_addr  = 3'd2,
    st_ack1  = 3'd3,
    st_data  = 3'd4,
    st_ack2  = 3'd5,
    st_stop  = 3'd6
  } i2c_state_t;

endpackage

// ==== i2c_bit_timer.sv ====
`timescale 1ns/1ps
`include "i2c_macros.svh"

module i2c_bit_timer (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  output i2c_pkg::i2c_phase_t phase,
  output logic                phase_tick,
  output logic                scl
);
  import i2c_pkg::*;

  localparam int CNT_W = (`I2C_PHASE_CYCLES > 1) ? $clog2(`I2C_PHASE_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`I2C_PHASE_CYCLES - 1);

  logic [CNT_W-1:0] cnt;
  logic [1:0]       phase_next;

  // last cycle of the current quarter.
  assign phase_tick = (cnt == CNT_MAX);
  assign phase_next = phase + 2'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt   <= '0;
      phase <= ph_high;
    end else if (!run) begin
      cnt   <= '0; // park with scl released high.
      phase <= ph_high;
    end else if (phase_tick) begin
      cnt   <= '0;
      phase <= i2c_phase_t'(phase_next);
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // scl only high in the middle two quarters.
  assign scl = (phase == ph_rise) || (phase == ph_high);

endmodule

// ==== i2c_shift_reg.sv ====
`timescale 1ns/1ps
`include "i2c_macros.svh"

module i2c_shift_reg (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load,
  input  logic [`I2C_DATA_W-1:0] load_value,
  input  logic                   shift,
  input  logic                   sample,
  input  logic                   sda_in,
  output logic                   tx_bit,
  output logic [`I2C_DATA_W-1:0] value
);

  logic [`I2C_DATA_W-1:0] sr;
  logic                   hold_bit;

  // bus bit taken at the end of scl high.
  always_ff @(posedge clk) begin
    if (sample) begin
      hold_bit <= sda_in;
    end
  end

  // shifting happens with scl low, so the msb moves only then.
  always_ff @(posedge clk) begin
    if (reset) begin
      sr <= '0;
    end else if (load) begin
      sr <= load_value;
    end else if (shift) begin
      sr <= {sr[`I2C_DATA_W-2:0], hold_bit};
    end
  end

  assign tx_bit = sr[`I2C_DATA_W-1]; // msb first on the wire.
  assign value  = sr;

endmodule

// ==== i2c_master_ctrl.sv ====
`timescale 1ns/1ps
`include "i2c_macros.svh"

module i2c_master_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic                   rw,
  input  logic [`I2C_ADDR_W-1:0] addr,
  input  logic [`I2C_DATA_W-1:0] wdata,
  input  logic                   sda_in,
  input  i2c_pkg::i2c_phase_t    phase,
  input  logic                   phase_tick,
  output logic                   timer_run,
  output logic                   load,
  output logic [`I2C_DATA_W-1:0] load_value,
  output logic                   shift,
  output logic                   sample,
  output logic                   sda_oe,
  output logic                   busy,
  output logic                   done,
  output logic                   ack_error,
  output logic                   latch,
  output logic [`I2C_ADDR_W-1:0] latch_addr,
  output logic [`I2C_DATA_W-1:0] latch_data,
  input  logic                   tx_bit,
  input  logic [`I2C_DATA_W-1:0] value
);
  import i2c_pkg::*;

  i2c_state_t             state;
  logic [2:0]             bit_cnt;
  logic                   rw_q;
  logic [`I2C_ADDR_W-1:0] addr_q;
  logic [`I2C_DATA_W-1:0] wdata_q;
  logic                   end_high;
  logic                   end_fall;
  logic                   byte_state;

  assign end_high   = phase_tick && (phase == ph_high);
  assign end_fall   = phase_tick && (phase == ph_fall);
  assign byte_state = (state == st_addr) || (state == st_data);

  // request captured once, held for the whole transfer.
  always_ff @(posedge clk) begin
    if ((state == st_idle) && start) begin
      rw_q    <= rw;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      bit_cnt   <= '0;
      done      <= 1'b0;
      latch     <= 1'b0;
      ack_error <= 1'b0;
    end else begin
      done  <= 1'b0;
      latch <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state     <= st_start;
            ack_error <= 1'b0;
          end
        end
        st_start: begin
          bit_cnt <= '0;
          if (end_fall) begin
            state <= st_addr;
          end
        end
        st_addr: begin
          if (end_fall) begin
            bit_cnt <= bit_cnt + 3'd1; // wraps to 0 after the 8th bit.
            if (bit_cnt == 3'd7) begin
              state <= st_ack1;
            end
          end
        end
        st_ack1: begin
          if (end_high && sda_in) begin
            ack_error <= 1'b1; // no device answered.
          end
          if (end_fall) begin
            state <= ack_error ? st_stop : st_data;
          end
        end
        st_data: begin
          if (end_fall) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= st_ack2;
            end
          end
        end
        st_ack2: begin
          if (end_high && !rw_q && sda_in) begin
            ack_error <= 1'b1;
          end
          if (end_fall) begin
            state <= st_stop;
          end
        end
        st_stop: begin
          if (end_high) begin
            state <= st_idle;
            done  <= 1'b1;
            latch <= !ack_error;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // stop the timer in the last stop cycle so scl stays high.
  assign timer_run = (state != st_idle) && !((state == st_stop) && end_high);

  assign load = end_fall &&
                ((state == st_start) || ((state == st_ack1) && !ack_error && !rw_q));
  assign load_value = (state == st_start) ? {addr_q, rw_q} : wdata_q;
  assign sample     = end_high && byte_state;
  assign shift      = end_fall && byte_state;

  always_comb begin
    case (state)
      st_start: sda_oe = 1'b1;
      st_addr:  sda_oe = !tx_bit;
      st_data:  sda_oe = !rw_q && !tx_bit; // released while reading.
      st_stop:  sda_oe = (phase != ph_high);
      default:  sda_oe = 1'b0;
    endcase
  end

  assign busy       = (state != st_idle);
  assign latch_addr = addr_q;
  assign latch_data = value; // byte on the wire, for both directions.

endmodule

// ==== seven_seg_driver.sv ====
`timescale 1ns/1ps
`include "i2c_macros.svh"

module seven_seg_driver (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   latch,
  input  logic [`I2C_ADDR_W-1:0] latch_addr,
  input  logic [`I2C_DATA_W-1:0] latch_data,
  output logic [`I2C_ADDR_W-1:0] led_addr,
  output logic [1:0]             anode,
  output logic [6:0]             cathode
);

  logic [`I2C_DATA_W-1:0]       shown_data;
  logic [`SEG_REFRESH_BITS-1:0] refresh_cnt;
  logic                         digit_sel;
  logic [3:0]                   nibble;

  // gfedcba, active high before inversion.
  function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
    case (hex)
      4'h0: hex_to_seg = 7'h3f;
      4'h1: hex_to_seg = 7'h06;
      4'h2: hex_to_seg = 7'h5b;
      4'h3: hex_to_seg = 7'h4f;
      4'h4: hex_to_seg = 7'h66;
      4'h5: hex_to_seg = 7'h6d;
      4'h6: hex_to_seg = 7'h7d;
      4'h7: hex_to_seg = 7'h07;
      4'h8: hex_to_seg = 7'h7f;
      4'h9: hex_to_seg = 7'h6f;
      4'ha: hex_to_seg = 7'h77;
      4'hb: hex_to_seg = 7'h7c;
      4'hc: hex_to_seg = 7'h39;
      4'hd: hex_to_seg = 7'h5e;
      4'he: hex_to_seg = 7'h79;
      default: hex_to_seg = 7'h71;
    endcase
  endfunction

  // last good transfer only.
  always_ff @(posedge clk) begin
    if (reset) begin
      led_addr   <= '0;
      shown_data <= '0;
    end else if (latch) begin
      led_addr   <= latch_addr;
      shown_data <= latch_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      refresh_cnt <= '0;
      digit_sel   <= 1'b0;
    end else begin
      refresh_cnt <= refresh_cnt + 1'b1;
      if (refresh_cnt == '1) begin
        digit_sel <= !digit_sel; // one full count per digit.
      end
    end
  end

  assign anode     = digit_sel ? 2'b10 : 2'b01;
  assign nibble    = digit_sel ? shown_data[7:4] : shown_data[3:0];
  assign cathode   = ~hex_to_seg(nibble); // segments sink current.

endmodule

// ==== i2c_seven_seg_top.sv ====
`timescale 1ns/1ps
`include "i2c_macros.svh"

module i2c_seven_seg_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic                   rw,
  input  logic [`I2C_ADDR_W-1:0] addr,
  input  logic [`I2C_DATA_W-1:0] wdata,
  input  logic                   sda_in,
  output logic                   scl,
  output logic                   sda_oe,
  output logic                   busy,
  output logic                   done,
  output logic                   ack_error,
  output logic [`I2C_DATA_W-1:0] rdata,
  output logic [`I2C_ADDR_W-1:0] led_addr,
  output logic [1:0]             anode,
  output logic [6:0]             cathode
);
  import i2c_pkg::*;

  i2c_phase_t             phase;
  logic                   phase_tick;
  logic                   timer_run;
  logic                   load;
  logic [`I2C_DATA_W-1:0] load_value;
  logic                   shift;
  logic                   sample;
  logic                   tx_bit;
  logic                   latch;
  logic [`I2C_ADDR_W-1:0] latch_addr;
  logic [`I2C_DATA_W-1:0] latch_data;

  i2c_bit_timer u_bit_timer (
    .clk        (clk),
    .reset      (reset),
    .run        (timer_run),
    .phase      (phase),
    .phase_tick (phase_tick),
    .scl        (scl)
  );

  // parallel value doubles as the read result.
  i2c_shift_reg u_shift_reg (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .load_value (load_value),
    .shift      (shift),
    .sample     (sample),
    .sda_in     (sda_in),
    .tx_bit     (tx_bit),
    .value      (rdata)
  );

  i2c_master_ctrl u_master_ctrl (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .rw         (rw),
    .addr       (addr),
    .wdata      (wdata),
    .sda_in     (sda_in),
    .phase      (phase),
    .phase_tick (phase_tick),
    .timer_run  (timer_run),
    .load       (load),
    .load_value (load_value),
    .shift      (shift),
    .sample     (sample),
    .sda_oe     (sda_oe),
    .busy       (busy),
    .done       (done),
    .ack_error  (ack_error),
    .latch      (latch),
    .latch_addr (latch_addr),
    .latch_data (latch_data),
    .tx_bit     (tx_bit),
    .value      (rdata)
  );

  seven_seg_driver u_seven_seg (
    .clk        (clk),
    .reset      (reset),
    .latch      (latch),
    .latch_addr (latch_addr),
    .latch_data (latch_data),
    .led_addr   (led_addr),
    .anode      (anode),
    .cathode    (cathode)
  );

endmodule

// ==== tb_i2c_slave_model.sv ====
`timescale 1ns/1ps

module tb_i2c_slave_model (
  input  logic       clk,
  input  logic       reset,
  input  logic       scl,
  input  logic       sda,
  output logic       sda_pull,
  output logic [7:0] reg_value,
  output logic [7:0] rx_count
);

  localparam logic [6:0] DEV_ADDR = 7'h44;

  typedef enum logic [2:0] {
    s_idle,
    s_addr,
    s_ack_addr,
    s_wr,
    s_ack_wr,
    s_rd
  } slave_state_t;

  slave_state_t state;
  logic         scl_q;
  logic         sda_q;
  logic         rw_bit;
  logic [3:0]   cnt;
  logic [7:0]   rx_sh;
  logic [7:0]   tx_sh;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= s_idle;
      scl_q     <= 1'b1;
      sda_q     <= 1'b1;
      sda_pull  <= 1'b0;
      rw_bit    <= 1'b0;
      cnt       <= '0;
      rx_sh     <= '0;
      tx_sh     <= '0;
      reg_value <= '0;
      rx_count  <= '0;
    end else begin
      scl_q <= scl;
      sda_q <= sda;
      if (scl && scl_q && sda_q && !sda) begin
        state    <= s_addr; // start condition.
        cnt      <= '0;
        sda_pull <= 1'b0;
      end else if (scl && scl_q && !sda_q && sda) begin
        state    <= s_idle; // stop condition.
        sda_pull <= 1'b0;
      end else if (scl && !scl_q) begin
        if ((state == s_addr) || (state == s_wr)) begin
          rx_sh <= {rx_sh[6:0], sda};
          cnt   <= cnt + 4'd1;
        end else if (state == s_rd) begin
          cnt <= cnt + 4'd1;
        end
      end else if (!scl && scl_q) begin
        // drive changes only right after scl falls.
        case (state)
          s_addr: begin
            if (cnt == 4'd8) begin
              if (rx_sh[7:1] == DEV_ADDR) begin
                sda_pull <= 1'b1;
                rw_bit   <= rx_sh[0];
                state    <= s_ack_addr;
              end else begin
                state <= s_idle; // not ours, stay quiet.
              end
            end
          end
          s_ack_addr: begin
            cnt <= '0;
            if (rw_bit) begin
              state    <= s_rd;
              sda_pull <= !reg_value[7];
              tx_sh    <= {reg_value[6:0], 1'b0};
            end else begin
              state    <= s_wr;
              sda_pull <= 1'b0;
            end
          end
          s_wr: begin
            if (cnt == 4'd8) begin
              reg_value <= rx_sh;
              rx_count  <= rx_count + 8'd1;
              sda_pull  <= 1'b1;
              state     <= s_ack_wr;
            end
          end
          s_ack_wr: begin
            sda_pull <= 1'b0;
            state    <= s_idle;
          end
          s_rd: begin
            if (cnt == 4'd8) begin
              sda_pull <= 1'b0; // master answers this one.
              state    <= s_idle;
            end else begin
              sda_pull <= !tx_sh[7];
              tx_sh    <= {tx_sh[6:0], 1'b0};
            end
          end
          default: state <= s_idle;
        endcase
      end
    end
  end

endmodule

// ==== tb_i2c_seven_seg.sv ====
`timescale 1ns/1ps
`include "i2c_macros.svh"

module tb_i2c_seven_seg;

  localparam logic [6:0] SLAVE_ADDR   = 7'h44;
  localparam logic [6:0] OTHER_ADDR   = 7'h21;
  localparam int         DONE_TIMEOUT = 1000;
  localparam int         QUIET_CYCLES = 400;
  localparam int         REFRESH_PERIOD = 1 << `SEG_REFRESH_BITS;

  logic                   clk;
  logic                   reset;
  logic                   start;
  logic                   rw;
  logic [`I2C_ADDR_W-1:0] addr;
  logic [`I2C_DATA_W-1:0] wdata;
  logic                   sda;
  logic                   scl;
  logic                   sda_oe;
  logic                   busy;
  logic                   done;
  logic                   ack_error;
  logic [`I2C_DATA_W-1:0] rdata;
  logic [`I2C_ADDR_W-1:0] led_addr;
  logic [1:0]             anode;
  logic [6:0]             cathode;
  logic                   slave_pull;
  logic [7:0]             slave_reg;
  logic [7:0]             slave_rx_count;

  logic [31:0] lfsr;
  int          starts_accepted;
  int          dones_seen;
  logic        req_rw;
  logic [6:0]  req_addr;
  logic [7:0]  req_wdata;
  logic [6:0]  exp_addr;
  logic [7:0]  exp_data;
  logic [7:0]  exp_slave_reg;
  logic [1:0]  anode_prev;
  int          anode_run;
  logic        prev_scl;
  logic        prev_sda;
  logic        in_xfer;
  int          scl_rises;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  assign sda = !(sda_oe || slave_pull); // open-drain wired-and.

  i2c_seven_seg_top u_i2c_seven_seg_top (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .rw        (rw),
    .addr      (addr),
    .wdata     (wdata),
    .sda_in    (sda),
    .scl       (scl),
    .sda_oe    (sda_oe),
    .busy      (busy),
    .done      (done),
    .ack_error (ack_error),
    .rdata     (rdata),
    .led_addr  (led_addr),
    .anode     (anode),
    .cathode   (cathode)
  );

  tb_i2c_slave_model u_slave (
    .clk       (clk),
    .reset     (reset),
    .scl       (scl),
    .sda       (sda),
    .sda_pull  (slave_pull),
    .reg_value (slave_reg),
    .rx_count  (slave_rx_count)
  );

  // lit segments low, gfedcba.
  function automatic logic [6:0] seg_active_low(input logic [3:0] hex);
    case (hex)
      4'h0: seg_active_low = 7'b1000000;
      4'h1: seg_active_low = 7'b1111001;
      4'h2: seg_active_low = 7'b0100100;
      4'h3: seg_active_low = 7'b0110000;
      4'h4: seg_active_low = 7'b0011001;
      4'h5: seg_active_low = 7'b0010010;
      4'h6: seg_active_low = 7'b0000010;
      4'h7: seg_active_low = 7'b1111000;
      4'h8: seg_active_low = 7'b0000000;
      4'h9: seg_active_low = 7'b0010000;
      4'ha: seg_active_low = 7'b0001000;
      4'hb: seg_active_low = 7'b0000011;
      4'hc: seg_active_low = 7'b1000110;
      4'hd: seg_active_low = 7'b0100001;
      4'he: seg_active_low = 7'b0000110;
      default: seg_active_low = 7'b0001110;
    endcase
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic issue_start(input logic r, input logic [6:0] a, input logic [7:0] d,
                             input logic accepted);
    @(posedge clk);
    #1;
    start = 1'b1;
    rw    = r;
    addr  = a;
    wdata = d;
    if (accepted) begin
      starts_accepted++;
      req_rw    = r;
      req_addr  = a;
      req_wdata = d;
    end
    @(posedge clk);
    #1;
    start = 1'b0;
    if (accepted) begin
      @(negedge clk);
      assert (busy) else abort_run($sformatf("error at %0t ns: busy not set after start", $time));
    end
  endtask

  task automatic wait_for_done(output logic err, output logic [7:0] rd);
    int  cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (cycles < DONE_TIMEOUT)) begin
      @(negedge clk);
      cycles++;
      if (done) begin
        seen = 1'b1;
        err  = ack_error;
        rd   = rdata;
      end
    end
    if (!seen) begin
      abort_run("timed out waiting for the done pulse");
    end
  endtask

  // done, display and led checks.
  always @(negedge clk) begin
    if (reset) begin
      exp_addr   = '0;
      exp_data   = '0;
      dones_seen = 0;
      anode_prev = 2'b01;
      anode_run  = 0;
    end else begin
      assert (anode == 2'b01 || anode == 2'b10)
        else abort_run($sformatf("error at %0t ns: anode not one-hot %b", $time, anode));
      if (anode == anode_prev) begin
        anode_run++;
        assert (anode_run <= REFRESH_PERIOD)
          else abort_run($sformatf("error at %0t ns: anode held for %0d cycles", $time,
                                   anode_run));
      end else begin
        assert (anode_run == REFRESH_PERIOD)
          else abort_run($sformatf("error at %0t ns: anode switched after %0d cycles", $time,
                                   anode_run));
        anode_run = 1;
      end
      anode_prev = anode;
      assert (cathode == seg_active_low(anode == 2'b01 ? exp_data[3:0] : exp_data[7:4]))
        else abort_run($sformatf("error at %0t ns: cathode %b for data %h", $time,
                                 cathode, exp_data));
      assert (led_addr == exp_addr)
        else abort_run($sformatf("error at %0t ns: led_addr %h expected %h", $time,
                                 led_addr, exp_addr));
      if (done) begin
        assert (dones_seen < starts_accepted)
          else abort_run($sformatf("error at %0t ns: done without an accepted start", $time));
        dones_seen++;
        if (!ack_error) begin
          exp_addr = req_addr; // display follows one cycle later.
          exp_data = req_rw ? exp_slave_reg : req_wdata;
        end
      end
    end
  end

  // sda may change under high scl only as start or stop.
  always @(negedge clk) begin
    if (reset) begin
      prev_scl  = 1'b1;
      prev_sda  = 1'b1;
      in_xfer   = 1'b0;
      scl_rises = 0;
    end else begin
      if (scl && !prev_scl) begin
        scl_rises++;
      end
      if (scl && prev_scl && (sda != prev_sda)) begin
        if (!sda) begin
          assert (!in_xfer && busy)
            else abort_run($sformatf("error at %0t ns: sda fell during scl high", $time));
          in_xfer   = 1'b1;
          scl_rises = 0;
        end else begin
          assert (in_xfer && (scl_rises == 19 || scl_rises == 10))
            else abort_run($sformatf("error at %0t ns: sda rose after %0d scl pulses",
                                     $time, scl_rises));
          in_xfer = 1'b0;
        end
      end
      prev_scl = scl;
      prev_sda = sda;
    end
  end

  initial begin
    #1_000_000;
    abort_run("simulation ran past its time limit");
  end

  initial begin
    logic       err;
    logic [7:0] rd;
    logic [7:0] b;
    logic [7:0] count_before;
    reset           = 1'b1;
    start           = 1'b0;
    rw              = 1'b0;
    addr            = '0;
    wdata           = '0;
    lfsr            = 32'h44ff;
    starts_accepted = 0;
    req_rw          = 1'b0;
    req_addr        = '0;
    req_wdata       = '0;
    exp_slave_reg   = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    repeat (6) begin
      @(negedge clk);
      assert (scl && !sda_oe && !busy && !done && !ack_error)
        else abort_run($sformatf("error at %0t ns: outputs not at reset values", $time));
    end

    // write to the slave.
    random_byte(b);
    count_before = slave_rx_count;
    issue_start(1'b0, SLAVE_ADDR, b, 1'b1);
    wait_for_done(err, rd);
    assert (!err) else abort_run($sformatf("error at %0t ns: write got ack_error", $time));
    assert (slave_reg == b)
      else abort_run($sformatf("error at %0t ns: slave holds %h not %h", $time, slave_reg, b));
    assert (slave_rx_count == count_before + 8'd1)
      else abort_run($sformatf("error at %0t ns: slave byte count wrong", $time));
    exp_slave_reg = b;
    repeat (16) @(negedge clk);

    // read it back.
    issue_start(1'b1, SLAVE_ADDR, 8'h00, 1'b1);
    wait_for_done(err, rd);
    assert (!err) else abort_run($sformatf("error at %0t ns: read got ack_error", $time));
    assert (rd == slave_reg && rd == exp_slave_reg)
      else abort_run($sformatf("error at %0t ns: rdata %h expected %h", $time, rd,
                               exp_slave_reg));
    repeat (16) @(negedge clk);

    // nobody at this address.
    random_byte(b);
    count_before = slave_rx_count;
    issue_start(1'b0, OTHER_ADDR, b, 1'b1);
    wait_for_done(err, rd);
    assert (err) else abort_run($sformatf("error at %0t ns: missing ack_error on nack", $time));
    assert (slave_rx_count == count_before)
      else abort_run($sformatf("error at %0t ns: slave took a byte after nack", $time));
    repeat (16) @(negedge clk);

    // second start while busy is dropped.
    random_byte(b);
    issue_start(1'b0, SLAVE_ADDR, b, 1'b1);
    repeat (40) @(posedge clk);
    issue_start(1'b0, OTHER_ADDR, ~b, 1'b0);
    wait_for_done(err, rd);
    assert (!err && slave_reg == b)
      else abort_run($sformatf("error at %0t ns: transfer disturbed by extra start", $time));
    exp_slave_reg = b;
    repeat (QUIET_CYCLES) @(negedge clk);
    assert (!busy) else abort_run($sformatf("error at %0t ns: busy after ignored start", $time));

    // one more write after all that.
    random_byte(b);
    issue_start(1'b0, SLAVE_ADDR, b, 1'b1);
    wait_for_done(err, rd);
    assert (!err && slave_reg == b)
      else abort_run($sformatf("error at %0t ns: final write wrong", $time));
    exp_slave_reg = b;
    repeat (16) @(negedge clk);

    $display("Regression passed");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
i2c_pkg.sv
i2c_bit_timer.sv
i2c_shift_reg.sv
i2c_master_ctrl.sv
seven_seg_driver.sv
i2c_seven_seg_top.sv
tb_i2c_slave_model.sv
tb_i2c_seven_seg.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_i2c_seven_seg
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
